// ==== logic/alu_pipe.sv ====
`timescale 1ns/10ps

module alu_pipe (
	input  logic clk,
	input  logic reset,
	exec_if.pipe x
);
	import core_pkg::*;

	logic s1_valid;
	opcode_e s1_op;
	reg_id_t s1_rd;
	word_t s1_a, s1_b;
	imm_t s1_imm;
	word_t alu_out;
	logic done_q;
	reg_id_t rd_q;
	word_t result_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			done_q <= 1'b0;
		end else begin
			s1_valid <= x.issue;
			done_q <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_op <= x.opcode;
		s1_rd <= x.rd;
		s1_a <= x.src_a;
		s1_b <= x.src_b;
		s1_imm <= x.imm;
		rd_q <= s1_rd;
		result_q <= alu_out;
	end

	always_comb begin
		case (s1_op)
			OP_ADD:  alu_out = s1_a + s1_b;
			OP_SUB:  alu_out = s1_a - s1_b;
			OP_AND:  alu_out = s1_a & s1_b;
			OP_OR:   alu_out = s1_a | s1_b;
			OP_XOR:  alu_out = s1_a ^ s1_b;
			OP_ADDI: alu_out = s1_a + sext_imm(s1_imm);
			default: alu_out = '0;
		endcase
	end

	assign x.busy = 1'b0;  // fully pipelined
	assign x.done = done_q;
	assign x.done_rd = rd_q;
	assign x.result = result_q;

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
	input  logic clk,
	input  logic reset,
	mem_bus_if.responder ibus,
	mem_bus_if.responder dbus,
	output logic mem_req,
	output logic mem_we,
	output bus_pkg::addr_t mem_addr,
	output bus_pkg::bus_data_t mem_wdata,
	input  logic mem_ack,
	input  bus_pkg::bus_data_t mem_rdata
);
	import bus_pkg::*;

	arb_state_e state, state_next;
	logic grant_d;  // data side holds the grant
	logic granted;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			grant_d <= 1'b0;
		end else begin
			state <= state_next;
			if (state == IDLE)
				grant_d <= dbus.req;  // dbus wins a tie
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE:    if (dbus.req) state_next = DBUS;
			         else if (ibus.req) state_next = IBUS;
			IBUS:    if (!ibus.req) state_next = RELEASE;
			DBUS:    if (!dbus.req) state_next = RELEASE;
			default: if (!mem_ack) state_next = IDLE;
		endcase
	end

	assign granted = (state != IDLE);

	// external port follows the granted requester
	assign mem_req = (state == IBUS && ibus.req) || (state == DBUS && dbus.req);
	assign mem_we = grant_d ? dbus.we : ibus.we;
	assign mem_addr = grant_d ? dbus.addr : ibus.addr;
	assign mem_wdata = grant_d ? dbus.wdata : ibus.wdata;

	assign ibus.ack = granted && !grant_d && mem_ack;
	assign dbus.ack = granted && grant_d && mem_ack;
	assign ibus.rdata = mem_rdata;
	assign dbus.rdata = mem_rdata;

endmodule

// ==== logic/bus_pkg.sv ====
package bus_pkg;

	typedef logic [31:0] addr_t;      // byte address, word aligned on the bus
	typedef logic [31:0] bus_data_t;  // one bus data word

	// arbiter grant states
	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		IBUS    = 2'd1,  // fetch owns the port
		DBUS    = 2'd2,  // load/store owns the port
		RELEASE = 2'd3   // waiting for ack to fall
	} arb_state_e;

endpackage

// ==== logic/core_pkg.sv ====
package core_pkg;

	// instruction word layout
	// opcode[31:28] rd[27:24] rs[23:20] rt[19:16] imm[15:0]
	// R-type: rd = rs op rt, ADDI/LOAD use rs + imm, STORE writes rt to rs + imm
	// BEQ/BNE compare rs with rt, target = pc + 4 + imm * 4

	typedef logic [31:0] word_t;   // register or data value
	typedef logic [3:0] reg_id_t;  // register index
	typedef logic [15:0] imm_t;    // raw immediate field

	localparam int NUM_REGS = 16;
	localparam reg_id_t REG_ZERO = 4'd0;  // always reads zero
	localparam int NUM_OPCODES = 12;

	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_AND   = 4'h2,
		OP_OR    = 4'h3,
		OP_XOR   = 4'h4,
		OP_ADDI  = 4'h5,
		OP_LOAD  = 4'h6,
		OP_STORE = 4'h7,
		OP_BEQ   = 4'h8,
		OP_BNE   = 4'h9,
		OP_HALT  = 4'ha,
		OP_NOP   = 4'hb
	} opcode_e;

	// immediates are signed everywhere they are used
	function automatic word_t sext_imm(input imm_t imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// codes above NOP are not part of the ISA
	function automatic logic opcode_defined(input logic [3:0] code);
		return code < 4'(NUM_OPCODES);
	endfunction

endpackage

// ==== logic/decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit #(
	parameter int DQ_DEPTH = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic flush,
	input  logic fq_valid,
	input  core_pkg::word_t fq_word,
	input  bus_pkg::addr_t fq_pc,
	output logic fq_deq,
	uop_if.producer uop
);
	import core_pkg::*;
	import bus_pkg::*;

	localparam int PTR_W = (DQ_DEPTH > 1) ? $clog2(DQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(DQ_DEPTH + 1);

	opcode_e q_op [DQ_DEPTH];
	reg_id_t q_rd [DQ_DEPTH];
	reg_id_t q_rs [DQ_DEPTH];
	reg_id_t q_rt [DQ_DEPTH];
	imm_t q_imm [DQ_DEPTH];
	addr_t q_pc [DQ_DEPTH];
	logic [PTR_W-1:0] rd_ptr, wr_ptr;
	logic [CNT_W-1:0] count;
	logic known, room, push, pop;

	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign known = opcode_defined(fq_word[31:28]);
	assign room = (count < CNT_W'(DQ_DEPTH));
	assign fq_deq = fq_valid && !flush && (room || !known);  // bad words always drain
	assign push = fq_deq && known;
	assign pop = uop.pop && uop.valid && !flush;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= bump(wr_ptr);
			if (pop)
				rd_ptr <= bump(rd_ptr);
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// field split of the fixed 32-bit format
	always_ff @(posedge clk) begin
		if (push) begin
			q_op[wr_ptr] <= opcode_e'(fq_word[31:28]);
			q_rd[wr_ptr] <= fq_word[27:24];
			q_rs[wr_ptr] <= fq_word[23:20];
			q_rt[wr_ptr] <= fq_word[19:16];
			q_imm[wr_ptr] <= fq_word[15:0];
			q_pc[wr_ptr] <= fq_pc;
		end
	end

	assign uop.valid = (count != '0);
	assign uop.opcode = q_op[rd_ptr];
	assign uop.rd = q_rd[rd_ptr];
	assign uop.rs = q_rs[rd_ptr];
	assign uop.rt = q_rt[rd_ptr];
	assign uop.imm = q_imm[rd_ptr];
	assign uop.pc = q_pc[rd_ptr];

endmodule

// ==== logic/exec_if.sv ====
`timescale 1ns/10ps

// issue and completion between dispatch and one execution pipe
interface exec_if;
	import core_pkg::*;

	logic issue;  // one cycle per operation
	opcode_e opcode;
	reg_id_t rd;
	word_t src_a;
	word_t src_b;
	imm_t imm;
	logic busy;
	logic done;   // one cycle, done_rd and result valid
	reg_id_t done_rd;
	word_t result;

	modport dispatch (output issue, opcode, rd, src_a, src_b, imm,
		input busy, done, done_rd, result);
	modport pipe (input issue, opcode, rd, src_a, src_b, imm,
		output busy, done, done_rd, result);

endinterface

// ==== logic/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit #(
	parameter int FQ_DEPTH = 4
) (
	input  logic clk,
	input  logic reset,
	mem_bus_if.requester ibus,
	input  bus_pkg::addr_t entry,
	input  logic redirect,
	input  bus_pkg::addr_t redirect_pc,
	input  logic deq,
	output logic head_valid,
	output core_pkg::word_t head_word,
	output bus_pkg::addr_t head_pc
);
	import core_pkg::*;
	import bus_pkg::*;

	localparam int PTR_W = (FQ_DEPTH > 1) ? $clog2(FQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(FQ_DEPTH + 1);

	typedef enum logic [1:0] {F_IDLE, F_REQ, F_RELEASE} fetch_state_e;

	fetch_state_e state;
	addr_t fetch_addr;  // next word to request
	addr_t req_addr;    // word on the bus
	logic discard;      // in-flight response is from a stale path
	logic stopped;      // HALT fetched, bus stays quiet until redirect
	word_t q_word [FQ_DEPTH];
	addr_t q_pc [FQ_DEPTH];
	logic [PTR_W-1:0] rd_ptr, wr_ptr;
	logic [CNT_W-1:0] count;
	logic push, pop, launch;

	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push = (state == F_REQ) && ibus.ack && !discard && !redirect;
	assign pop = deq && head_valid && !redirect;
	// next req one cycle after ack falls
	assign launch = !stopped && !redirect && (count < CNT_W'(FQ_DEPTH)) &&
		((state == F_IDLE) || (state == F_RELEASE && !ibus.ack));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= F_IDLE;
			fetch_addr <= entry;
			req_addr <= entry;
			discard <= 1'b0;
			stopped <= 1'b0;
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			case (state)
				F_IDLE:  if (launch) state <= F_REQ;
				F_REQ:   if (ibus.ack) state <= F_RELEASE;
				default: if (!ibus.ack) state <= launch ? F_REQ : F_IDLE;
			endcase
			if (launch) begin
				req_addr <= fetch_addr;
				fetch_addr <= fetch_addr + 32'd4;
			end
			if (state == F_REQ && ibus.ack)
				discard <= 1'b0;
			if (redirect) begin
				fetch_addr <= redirect_pc;
				discard <= (state == F_REQ) && !ibus.ack;
				stopped <= 1'b0;
				rd_ptr <= '0;
				wr_ptr <= '0;
				count <= '0;
			end else begin
				if (push && ibus.rdata[31:28] == OP_HALT)
					stopped <= 1'b1;
				if (push)
					wr_ptr <= bump(wr_ptr);
				if (pop)
					rd_ptr <= bump(rd_ptr);
				count <= count + CNT_W'(push) - CNT_W'(pop);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_word[wr_ptr] <= ibus.rdata;
			q_pc[wr_ptr] <= req_addr;
		end
	end

	assign ibus.req = (state == F_REQ);
	assign ibus.we = 1'b0;  // fetch only reads
	assign ibus.addr = req_addr;
	assign ibus.wdata = '0;

	assign head_valid = (count != '0);
	assign head_word = q_word[rd_ptr];
	assign head_pc = q_pc[rd_ptr];

endmodule

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/10ps

// four-phase req/ack memory bus
interface mem_bus_if;
	import bus_pkg::*;

	logic req;
	logic ack;
	logic we;
	addr_t addr;
	bus_data_t wdata;
	bus_data_t rdata;  // valid while ack is high on a read

	modport requester (output req, we, addr, wdata, input ack, rdata);
	modport responder (input req, we, addr, wdata, output ack, rdata);

endinterface

// ==== logic/mem_pipe.sv ====
`timescale 1ns/10ps

module mem_pipe (
	input  logic clk,
	input  logic reset,
	exec_if.pipe x,
	mem_bus_if.requester dbus
);
	import core_pkg::*;
	import bus_pkg::*;

	typedef enum logic [1:0] {M_IDLE, M_REQ, M_RELEASE} mem_state_e;

	mem_state_e state;
	logic done_q;
	addr_t addr_q;
	bus_data_t wdata_q;
	word_t load_q;
	logic we_q;  // current op is a store
	reg_id_t rd_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= M_IDLE;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				M_IDLE: if (x.issue) state <= M_REQ;
				M_REQ:  if (dbus.ack) state <= M_RELEASE;
				default: begin
					if (!dbus.ack) begin  // handshake closed
						state <= M_IDLE;
						done_q <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (x.issue && state == M_IDLE) begin
			addr_q <= x.src_a + sext_imm(x.imm);
			we_q <= (x.opcode == OP_STORE);
			wdata_q <= x.src_b;
			rd_q <= x.rd;
		end
		if (state == M_REQ && dbus.ack && !we_q)
			load_q <= dbus.rdata;
	end

	assign dbus.req = (state == M_REQ);
	assign dbus.we = we_q;
	assign dbus.addr = addr_q;
	assign dbus.wdata = wdata_q;

	assign x.busy = (state != M_IDLE);
	assign x.done = done_q;
	assign x.done_rd = we_q ? REG_ZERO : rd_q;  // stores write nothing back
	assign x.result = load_q;

endmodule

// ==== logic/scalar_core.sv ====
`timescale 1ns/10ps

module scalar_core #(
	parameter int FQ_DEPTH = 4,
	parameter int DQ_DEPTH = 2
) (
	input  logic clk,
	input  logic reset,
	input  bus_pkg::addr_t entry,
	output logic mem_req,
	output logic mem_we,
	output bus_pkg::addr_t mem_addr,
	output bus_pkg::bus_data_t mem_wdata,
	input  logic mem_ack,
	input  bus_pkg::bus_data_t mem_rdata,
	output logic halted
);
	import core_pkg::*;
	import bus_pkg::*;

	mem_bus_if ibus ();
	mem_bus_if dbus ();
	uop_if uop ();
	exec_if alu_x ();
	exec_if mem_x ();

	logic fq_valid, fq_deq, redirect;
	word_t fq_word;
	addr_t fq_pc, redirect_pc;

	word_t regs [NUM_REGS];
	logic [NUM_REGS-1:0] sb, sb_set, sb_clr;  // busy bit per pending rd
	word_t op_a, op_b;
	logic is_alu, is_mem, is_br, is_halt;
	logic conflict, pipe_busy, go, taken;

	bus_arbiter arb_i (.clk(clk), .reset(reset), .ibus(ibus), .dbus(dbus),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata));

	fetch_unit #(.FQ_DEPTH(FQ_DEPTH)) fetch_i (.clk(clk), .reset(reset), .ibus(ibus),
		.entry(entry), .redirect(redirect), .redirect_pc(redirect_pc), .deq(fq_deq),
		.head_valid(fq_valid), .head_word(fq_word), .head_pc(fq_pc));

	decode_unit #(.DQ_DEPTH(DQ_DEPTH)) decode_i (.clk(clk), .reset(reset),
		.flush(redirect), .fq_valid(fq_valid), .fq_word(fq_word), .fq_pc(fq_pc),
		.fq_deq(fq_deq), .uop(uop));

	alu_pipe alu_i (.clk(clk), .reset(reset), .x(alu_x));
	mem_pipe mem_i (.clk(clk), .reset(reset), .x(mem_x), .dbus(dbus));

	assign op_a = (uop.rs == REG_ZERO) ? '0 : regs[uop.rs];
	assign op_b = (uop.rt == REG_ZERO) ? '0 : regs[uop.rt];

	always_comb begin
		is_alu = 1'b0;
		is_mem = 1'b0;
		is_br = 1'b0;
		is_halt = 1'b0;
		case (uop.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: is_alu = 1'b1;
			OP_LOAD, OP_STORE: is_mem = 1'b1;
			OP_BEQ, OP_BNE: is_br = 1'b1;
			OP_HALT: is_halt = 1'b1;
			default: is_alu = 1'b0;  // NOP just leaves the queue
		endcase
	end

	assign conflict = sb[uop.rs] | sb[uop.rt] | sb[uop.rd];
	// HALT waits until every earlier op has written back
	assign pipe_busy = (is_alu && alu_x.busy) || (is_mem && mem_x.busy) ||
		(is_halt && (mem_x.busy || sb != '0));
	assign go = uop.valid && !halted && !conflict && !pipe_busy;
	assign taken = is_br && ((uop.opcode == OP_BEQ) == (op_a == op_b));

	assign uop.pop = go;
	assign redirect = go && taken;  // also flushes decode
	assign redirect_pc = uop.pc + 32'd4 + (sext_imm(uop.imm) << 2);

	assign alu_x.issue = go && is_alu;
	assign mem_x.issue = go && is_mem;
	assign alu_x.opcode = uop.opcode;
	assign mem_x.opcode = uop.opcode;
	assign alu_x.rd = uop.rd;
	assign mem_x.rd = uop.rd;
	assign alu_x.src_a = op_a;
	assign mem_x.src_a = op_a;
	assign alu_x.src_b = op_b;
	assign mem_x.src_b = op_b;
	assign alu_x.imm = uop.imm;
	assign mem_x.imm = uop.imm;

	always_comb begin
		sb_set = '0;
		sb_clr = '0;
		if (go && (is_alu || uop.opcode == OP_LOAD) && uop.rd != REG_ZERO)
			sb_set[uop.rd] = 1'b1;
		if (alu_x.done)
			sb_clr[alu_x.done_rd] = 1'b1;
		if (mem_x.done)
			sb_clr[mem_x.done_rd] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sb <= '0;
			halted <= 1'b0;
		end else begin
			sb <= (sb & ~sb_clr) | sb_set;
			if (go && is_halt)
				halted <= 1'b1;
		end
	end

	// writeback, scoreboard keeps the two ports on different registers
	always_ff @(posedge clk) begin
		if (alu_x.done && alu_x.done_rd != REG_ZERO)
			regs[alu_x.done_rd] <= alu_x.result;
		if (mem_x.done && mem_x.done_rd != REG_ZERO)
			regs[mem_x.done_rd] <= mem_x.result;
	end

endmodule

// ==== logic/uop_if.sv ====
`timescale 1ns/10ps

// head of the decode queue as seen by dispatch
interface uop_if;
	import core_pkg::*;
	import bus_pkg::*;

	logic valid;
	opcode_e opcode;
	reg_id_t rd;
	reg_id_t rs;
	reg_id_t rt;
	imm_t imm;
	addr_t pc;
	logic pop;  // head leaves the queue at the edge

	modport producer (output valid, opcode, rd, rs, rt, imm, pc, input pop);
	modport consumer (input valid, opcode, rd, rs, rt, imm, pc, output pop);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scalar core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_scalar_core -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== tb.f ====
logic/core_pkg.sv
logic/bus_pkg.sv
logic/mem_bus_if.sv
logic/uop_if.sv
logic/exec_if.sv
logic/bus_arbiter.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/alu_pipe.sv
logic/mem_pipe.sv
logic/scalar_core.sv
verification/tb_scalar_core.sv

// ==== verification/tb_scalar_core.sv ====
`timescale 1ns/10ps

module tb_scalar_core;
	import core_pkg::*;
	import bus_pkg::*;

	localparam int MEM_WORDS = 256;      // 1 KB model memory
	localparam int HALT_LIMIT = 6000;    // cycles allowed per program
	localparam int RELEASE_LIMIT = 100;  // cycles for req to fall after ack

	logic clk = 1'b0;
	logic reset;
	addr_t entry;
	logic mem_req;
	logic mem_we;
	addr_t mem_addr;
	bus_data_t mem_wdata;
	logic mem_ack;
	bus_data_t mem_rdata;
	logic halted;

	word_t mem [MEM_WORDS];
	int load_idx;
	logic [31:0] rng = 32'd44694;
	int unsigned max_delay = 5;
	int unsigned ack_wait;
	int unsigned release_wait;
	int errors = 0;
	int test_start_errors;
	int tests_run = 0;
	int tests_failed = 0;
	string test_name;
	logic timed_out = 1'b0;

	scalar_core #(.FQ_DEPTH(4), .DQ_DEPTH(2)) scalar_core_i (.clk(clk), .reset(reset),
		.entry(entry), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata), .halted(halted));

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t encode(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt, input logic [15:0] imm);
		return {op, rd, rs, rt, imm};
	endfunction

	// opcode 0xc is undefined, so stray fetches of fill words get dropped
	function automatic word_t fill_word(input int idx);
		return 32'hc0de_0000 | word_t'(idx * 4);
	endfunction

	// memory side of the four-phase handshake, random ack delay
	always begin
		@(negedge clk);
		if (mem_req && !mem_ack && !reset) begin
			if (mem_addr[1:0] != 2'b00 || mem_addr >= addr_t'(MEM_WORDS * 4)) begin
				$display("bus error at %0t: address %h is unaligned or outside the memory",
					$time, mem_addr);
				errors++;
			end
			rng = xorshift32(rng);
			ack_wait = rng % (max_delay + 1);
			repeat (ack_wait) @(negedge clk);
			if (mem_we)
				mem[mem_addr[9:2]] = mem_wdata;
			else
				mem_rdata <= mem[mem_addr[9:2]];
			mem_ack <= 1'b1;
			release_wait = 0;
			do begin
				@(negedge clk);
				release_wait++;
			end while (mem_req && release_wait < RELEASE_LIMIT);
			if (mem_req) begin
				$display("bus timeout: mem_req still high %0d cycles after ack", RELEASE_LIMIT);
				timed_out = 1'b1;
				errors++;
			end
			mem_ack <= 1'b0;
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		int i;
		test_name = name;
		test_start_errors = errors;
		tests_run++;
		for (i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(i);
		load_idx = 0;
	endtask

	task automatic end_test();
		if (errors != test_start_errors) begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - test_start_errors);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	task automatic emit(input word_t w);
		mem[load_idx] = w;
		load_idx++;
	endtask

	// reset pulse, then wait for the core to halt
	task automatic run_program();
		int cycles;
		@(negedge clk);
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		check_flag("halted", halted, 1'b0);
		check_flag("mem_req", mem_req, 1'b0);
		cycles = 0;
		while (!halted && cycles < HALT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("timeout: halted did not rise within %0d cycles in %s",
				HALT_LIMIT, test_name);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic test_alu();
		begin_test("alu");
		emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd100));
		emit(encode(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'hfff9));  // -7
		emit(encode(OP_ADD, 4'd3, 4'd1, 4'd2, 16'd0));
		emit(encode(OP_SUB, 4'd4, 4'd1, 4'd2, 16'd0));
		emit(encode(OP_AND, 4'd5, 4'd1, 4'd2, 16'd0));
		emit(encode(OP_OR, 4'd6, 4'd1, 4'd2, 16'd0));
		emit(encode(OP_XOR, 4'd7, 4'd1, 4'd2, 16'd0));
		emit(encode(OP_ADDI, 4'd8, 4'd1, 4'd0, 16'hff6a));  // -150
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd2, 16'h0200));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd3, 16'h0204));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd4, 16'h0208));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd5, 16'h020c));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd6, 16'h0210));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd7, 16'h0214));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd8, 16'h0218));
		emit(encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0));
		run_program();
		check_word("addi negative", mem[128], 32'hffff_fff9);
		check_word("add", mem[129], 32'd93);
		check_word("sub", mem[130], 32'd107);
		check_word("and", mem[131], 32'h0000_0060);
		check_word("or", mem[132], 32'hffff_fffd);
		check_word("xor", mem[133], 32'hffff_ff9d);
		check_word("addi", mem[134], 32'hffff_ffce);  // 100 - 150
		end_test();
	endtask

	// raw, waw and load-use chain, shared by the back-pressure test
	task automatic load_hazard_program();
		mem[144] = 32'h0000_1234;  // load source at 0x240
		emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd5));
		emit(encode(OP_ADD, 4'd2, 4'd1, 4'd1, 16'd0));
		emit(encode(OP_ADDI, 4'd2, 4'd2, 4'd0, 16'd3));
		emit(encode(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'd20));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd2, 16'h0218));  // read right after the waw
		emit(encode(OP_LOAD, 4'd3, 4'd0, 4'd0, 16'h0240));
		emit(encode(OP_ADD, 4'd4, 4'd3, 4'd2, 16'd0));
		emit(encode(OP_SUB, 4'd5, 4'd4, 4'd1, 16'd0));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd2, 16'h0200));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd4, 16'h0204));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd5, 16'h0208));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd3, 16'h020c));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd5, 16'h0210));
		emit(encode(OP_LOAD, 4'd6, 4'd0, 4'd0, 16'h0210));
		emit(encode(OP_ADDI, 4'd6, 4'd6, 4'd0, 16'd1));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd6, 16'h0214));
		emit(encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0));
	endtask

	task automatic check_hazard_results();
		check_word("waw r2", mem[128], 32'd20);
		check_word("load use", mem[129], 32'h0000_1248);
		check_word("raw chain", mem[130], 32'h0000_1243);
		check_word("load", mem[131], 32'h0000_1234);
		check_word("store load", mem[133], 32'h0000_1244);
		check_word("raw r2", mem[134], 32'd20);
	endtask

	task automatic test_hazards();
		begin_test("hazards");
		load_hazard_program();
		run_program();
		check_hazard_results();
		end_test();
	endtask

	task automatic test_backpressure();
		begin_test("backpressure");
		max_delay = 24;
		load_hazard_program();
		run_program();
		max_delay = 5;
		check_hazard_results();
		end_test();
	endtask

	task automatic test_branches();
		begin_test("branches");
		emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'd3));
		emit(encode(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'd3));
		emit(encode(OP_ADDI, 4'd3, 4'd0, 4'd0, 16'd9));
		emit(encode(OP_BEQ, 4'd0, 4'd1, 4'd2, 16'd1));       // taken
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd3, 16'h0200));
		emit(encode(OP_BNE, 4'd0, 4'd1, 4'd2, 16'd1));       // not taken
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd3, 16'h0204));
		emit(encode(OP_BEQ, 4'd0, 4'd1, 4'd3, 16'd1));       // not taken
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd1, 16'h0208));
		emit(encode(OP_BNE, 4'd0, 4'd1, 4'd3, 16'd1));       // taken
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd3, 16'h020c));
		emit(encode(OP_ADDI, 4'd5, 4'd0, 4'd0, 16'd5));
		emit(encode(OP_ADDI, 4'd4, 4'd0, 4'd0, 16'd0));      // loop counter starts at zero
		emit(encode(OP_ADDI, 4'd4, 4'd4, 4'd0, 16'd1));      // loop body
		emit(encode(OP_BNE, 4'd0, 4'd4, 4'd5, 16'hfffe));    // back to the body
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd4, 16'h0210));
		emit(encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0));
		run_program();
		check_word("beq taken skip", mem[128], fill_word(128));
		check_word("bne not taken", mem[129], 32'd9);
		check_word("beq not taken", mem[130], 32'd3);
		check_word("bne taken skip", mem[131], fill_word(131));
		check_word("loop count", mem[132], 32'd5);
		end_test();
	endtask

	task automatic test_halt();
		int i;
		begin_test("halt");
		emit(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h0055));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd1, 16'h0200));
		emit(encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd1, 16'h0204));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd1, 16'h0208));
		run_program();
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_flag("halted", halted, 1'b1);
			check_flag("mem_req", mem_req, 1'b0);
		end
		check_word("store before halt", mem[128], 32'h0000_0055);
		check_word("store after halt", mem[129], fill_word(129));
		check_word("second store after halt", mem[130], fill_word(130));
		end_test();
	endtask

	task automatic test_edges();
		begin_test("edges");
		emit(encode(OP_ADDI, 4'd0, 4'd0, 4'd0, 16'd77));     // write to r0
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd0, 16'h0200));
		emit(encode(OP_ADD, 4'd1, 4'd0, 4'd0, 16'd0));
		emit(32'hf123_4567);                                 // undefined opcode
		emit(encode(OP_NOP, 4'd0, 4'd0, 4'd0, 16'd0));
		emit(32'hc000_0000);
		emit(encode(OP_ADDI, 4'd2, 4'd1, 4'd0, 16'h0042));
		emit(encode(OP_STORE, 4'd0, 4'd0, 4'd2, 16'h0204));
		emit(encode(OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0));
		run_program();
		check_word("r0 reads zero", mem[128], 32'd0);
		check_word("after undefined", mem[129], 32'h0000_0042);
		end_test();
	endtask

	initial begin
		reset = 1'b1;
		entry = '0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		repeat (3) @(negedge clk);
		test_alu();
		if (!timed_out)
			test_hazards();
		if (!timed_out)
			test_branches();
		if (!timed_out)
			test_backpressure();
		if (!timed_out)
			test_halt();
		if (!timed_out)
			test_edges();
		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
